// File: Makefile
# Verilator simulation of the error-capture block
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module errt_tb -Mdir obj_dir -f vlog.f
	./obj_dir/Verrt_tb | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: include/errt_params.svh
`ifndef ERRT_PARAMS_SVH
`define ERRT_PARAMS_SVH

// number of receiver channels, each with its own tracker and capture RAM
`define ERRT_NUM_CH 4

// capture RAM depth in frames is 2**ERRT_ADDR_W
`define ERRT_ADDR_W 4

// width of one signed error sample
`define ERRT_ERR_W 8

`endif

// File: sim/errt_props.sv
`include "errt_params.svh"

module errt_props (
	input logic                    clk,
	input logic                    rstb,
	input logic                    req,
	input logic                    ack,
	input errt_pkg::ctrl_state_t   state,
	input logic [`ERRT_NUM_CH-1:0] status
);
	timeunit 1ns;
	timeprecision 1ps;
	import errt_pkg::*;

	// four-phase host handshake
	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rstb) $rose(ack) |-> req)
		else $error("ack rose while req was low");
	a_ack_after_req: assert property (@(posedge clk) disable iff (!rstb)
		$fell(ack) |-> !$past(req)) else $error("ack fell before req fell");
	a_req_after_ack: assert property (@(posedge clk) disable iff (!rstb)
		$rose(req) |-> !$past(ack)) else $error("req rose while ack was still high");

	// a tracker leaves DONE only through a rearm issued by the controller
	a_done_clear: assert property (@(posedge clk) disable iff (!rstb)
		|($past(status) & ~status) |-> $past(state) == ISSUE)
		else $error("a done flag fell without a rearm");

endmodule : errt_props

bind readout_ctrl errt_props u_props (
	.clk    (clk),
	.rstb   (rstb),
	.req    (req),
	.ack    (ack),
	.state  (state),
	.status (status)
);

// File: sim/errt_tb.sv
`include "errt_params.svh"

module errt_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import errt_pkg::*;

	localparam int N_CH  = `ERRT_NUM_CH;
	localparam int DEPTH = 2**`ERRT_ADDR_W;
	localparam int ACCESS_CYC = 8; // one host access takes six cycles from req to ack low
	// two full readouts of two words per frame, plus the extra reads and the captures
	localparam int READS = 2 * 2 * (N_CH * DEPTH + 1) + 4;
	localparam int CYCLE_LIMIT = 2 * (16 + READS * ACCESS_CYC + 2 * (4 * DEPTH + 8));

	logic                          clk;
	logic                          rstb;
	logic                          trigger;
	logic signed [`ERRT_ERR_W-1:0] err [N_CH];
	logic [N_CH-1:0]               prbs_ok;
	logic [N_CH-1:0]               data_bit;
	logic                          req;
	logic                          rearm;
	logic [CH_W-1:0]               ch;
	logic [`ERRT_ADDR_W-1:0]       frame_addr;
	logic                          word_sel;
	logic                          ack;
	logic [31:0]                   rd_data;
	logic [N_CH-1:0]               cap_done;

	int errors;
	int accesses;
	int cycles;
	int n; // sample index, one step per cycle after reset

	errt_top UUT (
		.clk        (clk),
		.rstb       (rstb),
		.trigger    (trigger),
		.err        (err),
		.prbs_ok    (prbs_ok),
		.data_bit   (data_bit),
		.req        (req),
		.rearm      (rearm),
		.ch         (ch),
		.frame_addr (frame_addr),
		.word_sel   (word_sel),
		.ack        (ack),
		.rd_data    (rd_data),
		.cap_done   (cap_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin : sample_drive
		n        <= 0;
		prbs_ok  <= '0;
		data_bit <= '0;
		for (int c = 0; c < N_CH; c++) err[c] <= '0;
		@(posedge rstb);
		forever begin
			@(posedge clk);
			for (int c = 0; c < N_CH; c++) begin
				err[c]      <= `ERRT_ERR_W'(n + 16 * c); // each channel is offset by 16
				prbs_ok[c]  <= n[0] ^ c[0];
				data_bit[c] <= n[1];
			end
			n <= n + 1;
		end
	end

	initial begin : watchdog
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("ERROR: timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("closing: %0d check(s) failed, %0d host accesses, 1 timeout", errors, accesses);
		$display("STATUS: FAIL");
		$finish;
	end

	// the sample rule seen from the host side, four indices from first upward
	function automatic frame_t expected_frame(input int c, input int first);
		frame_t fr;
		int     idx;
		for (int k = 0; k < 4; k++) begin
			idx             = first + k;
			fr[k].err       = `ERRT_ERR_W'(idx + 16 * c);
			fr[k].prbs_ok   = idx[0] ^ c[0];
			fr[k].data_bit  = idx[1];
		end
		return fr;
	endfunction

	task automatic check_frame(input string name, input frame_t exp, input frame_t act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_done(input string name, input logic [N_CH-1:0] exp,
			input logic [N_CH-1:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_ack(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s: expected ack %b, actual %b", name, exp, act);
		end
	endtask

	// one four-phase transfer, entered and left on a rising edge
	task automatic host_access(input logic rearm_bit, input int ch_i, input int frame_i,
			input logic word_i, output logic [31:0] data);
		int lat;
		while (ack) @(posedge clk); // never raise req over a high ack
		req        <= 1'b1;
		rearm      <= rearm_bit;
		ch         <= CH_W'(ch_i);
		frame_addr <= `ERRT_ADDR_W'(frame_i);
		word_sel   <= word_i;
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!ack);
		if (lat < 3) begin
			errors++;
			$display("ERROR: ack came %0d cycles after req, sooner than the minimum of 3", lat);
		end
		data = rd_data;
		req <= 1'b0;
		do @(posedge clk); while (ack);
		accesses++;
	endtask

	task automatic host_read(input int ch_i, input int frame_i, input logic word_i,
			output logic [31:0] data);
		host_access(1'b0, ch_i, frame_i, word_i, data);
	endtask

	task automatic host_rearm();
		logic [31:0] unused;
		host_access(1'b1, 0, 0, 1'b0, unused);
	endtask

	// two reads rebuild one frame, word 1 carries only the top sample's error
	task automatic read_frame(input int c, input int f, input frame_t exp, output frame_t fr);
		logic [31:0] w0;
		logic [31:0] w1;
		host_read(c, f, 1'b0, w0);
		host_read(c, f, 1'b1, w1);
		check_word($sformatf("word 1 ch%0d frame%0d", c, f), {24'b0, exp[3].err}, w1);
		fr = {w1[7:0], w0};
	endtask

	task automatic start_capture(output int n_trig);
		trigger <= 1'b1;
		n_trig = n;
		@(posedge clk);
		trigger <= 1'b0;
		// every channel starts on the same frame, so all done flags should rise together
		while (cap_done === '0) @(posedge clk);
	endtask

	// reads every frame of every channel against the sample rule
	task automatic check_capture(input string name, input int n_trig);
		frame_t      fr;
		frame_t      exp;
		logic [31:0] w0;
		int          base;
		int          first;
		logic [7:0]  delta;
		host_read(0, 0, 1'b0, w0); // word 0 holds the oldest sample of frame 0
		fr    = {8'b0, w0};
		base  = n_trig - 16; // the 8-bit error only wraps every 256 samples
		delta = fr[0].err - 8'(base);
		first = base + int'(delta);
		if (first < n_trig - 3 || first > n_trig) begin
			errors++;
			$display("ERROR: %s started at sample %0d, trigger was at sample %0d",
				name, first, n_trig);
		end
		for (int c = 0; c < N_CH; c++) begin
			for (int f = 0; f < DEPTH; f++) begin
				exp = expected_frame(c, first + 4 * f);
				read_frame(c, f, exp, fr);
				check_frame($sformatf("%s ch%0d frame%0d", name, c, f), exp, fr);
			end
		end
	endtask

	task automatic test_reset();
		frame_t fr;
		check_ack("reset", 1'b0, ack);
		check_done("reset", '0, cap_done);
		read_frame(1, 3, '0, fr); // done is low, so the tracker returns zero
		check_frame("read before capture", '0, fr);
	endtask

	task automatic test_capture_rearm();
		int n_trig;
		start_capture(n_trig);
		check_done("first capture", '1, cap_done);
		check_capture("first capture", n_trig);
		host_rearm();
		check_done("rearm", '0, cap_done);
		start_capture(n_trig);
		check_done("second capture", '1, cap_done);
		check_capture("second capture", n_trig);
	endtask

	initial begin : main
		errors      = 0;
		accesses    = 0;
		rstb       <= 1'b0;
		trigger    <= 1'b0;
		req        <= 1'b0;
		rearm      <= 1'b0;
		ch         <= '0;
		frame_addr <= '0;
		word_sel   <= 1'b0;
		repeat (16) @(posedge clk);
		rstb <= 1'b1;
		@(posedge clk);
		test_reset();
		test_capture_rearm();
		$display("closing: %0d check(s) failed, %0d host accesses, 0 timeouts",
			errors, accesses);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule : errt_tb

// File: src/capture_ram.sv
`include "errt_params.svh"

module capture_ram (
	input  logic                    clk,
	input  logic                    we,
	input  logic [`ERRT_ADDR_W-1:0] addr,
	input  errt_pkg::frame_t        wdata,
	output errt_pkg::frame_t        rdata
);
	import errt_pkg::*;

	frame_t mem [2**`ERRT_ADDR_W];

	// single port, the read port returns the old contents on a write cycle
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule : capture_ram

// File: src/error_tracker.sv
`include "errt_params.svh"

module error_tracker (
	input logic             clk,
	input logic             rstb,
	input logic             trigger,
	input errt_pkg::frame_t frame,
	input logic             frame_valid,
	errt_rd_if.tracker      rd
);
	import errt_pkg::*;

	localparam logic [`ERRT_ADDR_W-1:0] LAST_ADDR = '1;

	trk_state_t              state;
	logic [`ERRT_ADDR_W-1:0] write_addr;
	logic [`ERRT_ADDR_W-1:0] ram_addr;
	logic                    ram_we;
	logic                    rd_vld; // RAM output holds the word asked for last cycle
	frame_t                  ram_q;

	// frames only go into the RAM while storing, anything else is dropped
	assign ram_we = (state == STORE) && frame_valid;

	// the host owns the address once the capture is complete
	assign ram_addr = (state == DONE) ? rd.addr : write_addr;

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state      <= READY;
			write_addr <= '0;
		end else begin
			unique case (state)
				READY: begin
					if (trigger) state <= STORE;
				end
				STORE: begin
					if (frame_valid) begin
						write_addr <= write_addr + 1'b1;
						if (write_addr == LAST_ADDR) state <= DONE; // RAM is full
					end
				end
				DONE: begin
					if (rd.rearm) begin
						state      <= READY;
						write_addr <= '0;
					end
				end
				default: state <= READY;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			rd_vld <= 1'b0;
		end else begin
			rd_vld <= rd.read && (state == DONE); // a read during capture is not served
		end
	end

	capture_ram u_ram (
		.clk   (clk),
		.we    (ram_we),
		.addr  (ram_addr),
		.wdata (frame),
		.rdata (ram_q)
	);

	assign rd.done = (state == DONE);
	assign rd.data = (rd_vld && state == DONE) ? ram_q : '0;

endmodule : error_tracker

// File: src/errt_pkg.sv
`include "errt_params.svh"

package errt_pkg;

	localparam int CH_W = $clog2(`ERRT_NUM_CH); // channel index width

	// one channel sample per cycle, 10 bits with the error in the top bits
	typedef struct packed {
		logic signed [`ERRT_ERR_W-1:0] err;
		logic                          prbs_ok;
		logic                          data_bit;
	} sample_t;

	typedef sample_t [3:0] frame_t; // element 0 is the oldest sample

	typedef struct packed {
		logic                    rearm;    // re-arm all trackers instead of reading
		logic [CH_W-1:0]         ch;
		logic [`ERRT_ADDR_W-1:0] frame_addr;
		logic                    word_sel; // word 1 carries frame bits 39..32
	} host_cmd_t;

	typedef enum logic [1:0] {READY, STORE, DONE} trk_state_t;

	typedef enum logic [1:0] {IDLE, ISSUE, WAIT, ACK} ctrl_state_t;

endpackage : errt_pkg

// File: src/errt_rd_if.sv
`include "errt_params.svh"

interface errt_rd_if;
	import errt_pkg::*;

	logic [`ERRT_ADDR_W-1:0] addr;  // frame address, held stable by the controller
	logic                    read;  // one-cycle pulse, data follows a cycle later
	logic                    rearm; // one-cycle pulse, only honoured in DONE
	frame_t                  data;
	logic                    done;

	modport tracker (
		input  addr,
		input  read,
		input  rearm,
		output data,
		output done
	);

	modport ctrl (
		output addr,
		output read,
		output rearm,
		input  data,
		input  done
	);

endinterface : errt_rd_if

// File: src/errt_top.sv
`include "errt_params.svh"

module errt_top (
	input  logic                          clk,
	input  logic                          rstb,
	input  logic                          trigger,
	input  logic signed [`ERRT_ERR_W-1:0] err [`ERRT_NUM_CH],
	input  logic [`ERRT_NUM_CH-1:0]       prbs_ok,
	input  logic [`ERRT_NUM_CH-1:0]       data_bit,
	input  logic                          req,
	input  logic                          rearm,
	input  logic [errt_pkg::CH_W-1:0]     ch,
	input  logic [`ERRT_ADDR_W-1:0]       frame_addr,
	input  logic                          word_sel,
	output logic                          ack,
	output logic [31:0]                   rd_data,
	output logic [`ERRT_NUM_CH-1:0]       cap_done
);
	import errt_pkg::*;

	sample_t   samples [`ERRT_NUM_CH];
	frame_t    frames [`ERRT_NUM_CH];
	logic      frame_valid;
	host_cmd_t cmd;

	errt_rd_if rd_if [`ERRT_NUM_CH] ();

	// gather the per-channel inputs into one sample each
	for (genvar g = 0; g < `ERRT_NUM_CH; g++) begin : g_smp
		assign samples[g] = '{err: err[g], prbs_ok: prbs_ok[g], data_bit: data_bit[g]};
	end

	assign cmd = '{rearm: rearm, ch: ch, frame_addr: frame_addr, word_sel: word_sel};

	frame_packer u_packer (
		.clk         (clk),
		.rstb        (rstb),
		.samples     (samples),
		.frames      (frames),
		.frame_valid (frame_valid)
	);

	for (genvar g = 0; g < `ERRT_NUM_CH; g++) begin : g_trk
		error_tracker u_trk (
			.clk         (clk),
			.rstb        (rstb),
			.trigger     (trigger), // one trigger starts every channel on the same frame
			.frame       (frames[g]),
			.frame_valid (frame_valid),
			.rd          (rd_if[g])
		);
	end

	readout_ctrl u_ctrl (
		.clk     (clk),
		.rstb    (rstb),
		.req     (req),
		.cmd     (cmd),
		.ack     (ack),
		.rd_data (rd_data),
		.status  (cap_done),
		.trk     (rd_if)
	);

endmodule : errt_top

// File: src/frame_packer.sv
`include "errt_params.svh"

module frame_packer (
	input  logic              clk,
	input  logic              rstb,
	input  errt_pkg::sample_t samples [`ERRT_NUM_CH],
	output errt_pkg::frame_t  frames [`ERRT_NUM_CH],
	output logic              frame_valid
);
	import errt_pkg::*;

	frame_t     shift_q [`ERRT_NUM_CH];
	logic [1:0] phase;

	// each cycle the new sample enters at the top and the oldest falls out at the bottom,
	// so after four shifts element 0 holds the first sample of the frame
	always_ff @(posedge clk) begin
		for (int c = 0; c < `ERRT_NUM_CH; c++) begin
			shift_q[c] <= {samples[c], shift_q[c][3:1]};
		end
	end

	// phase 0 is the first cycle after reset release
	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			phase       <= 2'd0;
			frame_valid <= 1'b0;
		end else begin
			phase       <= phase + 2'd1;
			frame_valid <= (phase == 2'd3); // the fourth sample lands on this edge
		end
	end

	// the frame stays complete for exactly the cycle in which frame_valid is high
	assign frames = shift_q;

endmodule : frame_packer

// File: src/readout_ctrl.sv
`include "errt_params.svh"

module readout_ctrl (
	input  logic                    clk,
	input  logic                    rstb,
	input  logic                    req,
	input  errt_pkg::host_cmd_t     cmd,
	output logic                    ack,
	output logic [31:0]             rd_data,
	output logic [`ERRT_NUM_CH-1:0] status,
	errt_rd_if.ctrl                 trk [`ERRT_NUM_CH]
);
	import errt_pkg::*;

	ctrl_state_t                 state;
	host_cmd_t                   cmd_q;
	frame_t                      ch_data [`ERRT_NUM_CH];
	logic [$bits(frame_t)-1:0]   sel_bits; // flat view of the selected frame
	logic [31:0]                 word;

	for (genvar g = 0; g < `ERRT_NUM_CH; g++) begin : g_ch
		assign trk[g].addr  = cmd_q.frame_addr;
		assign trk[g].read  = (state == ISSUE) && !cmd_q.rearm && (cmd_q.ch == CH_W'(g));
		assign trk[g].rearm = (state == ISSUE) && cmd_q.rearm; // re-arm goes to every channel
		assign ch_data[g]   = trk[g].data;
		assign status[g]    = trk[g].done;
	end

	assign sel_bits = ch_data[cmd_q.ch];

	// word 1 is the top sample's error, zero-extended
	assign word = cmd_q.word_sel ? 32'(sel_bits[$bits(frame_t)-1:32]) : sel_bits[31:0];

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= IDLE;
			ack   <= 1'b0;
		end else begin
			unique case (state)
				IDLE: begin
					if (req) state <= ISSUE;
				end
				ISSUE: state <= WAIT; // read or rearm pulses during this cycle
				WAIT: begin
					state <= ACK;
					ack   <= 1'b1;
				end
				ACK: begin
					if (!req) begin // hold ack until the host lets go of req
						state <= IDLE;
						ack   <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req) cmd_q <= cmd;
		if (state == WAIT) rd_data <= word; // tracker data is valid in this cycle
	end

endmodule : readout_ctrl

// File: vlog.f
+incdir+include
src/errt_pkg.sv
src/errt_rd_if.sv
src/frame_packer.sv
src/capture_ram.sv
src/error_tracker.sv
src/readout_ctrl.sv
src/errt_top.sv
sim/errt_props.sv
sim/errt_tb.sv
